/* common/icache_pkg.sv */
package icache_pkg;

   // ######################################################################
   // address geometry
   // ######################################################################
   localparam int bus_addr_width = 20;
   localparam int index_width = 4; // 16 lines.
   localparam int offset_width = 5; // 32 words per line.
   localparam int beat_count_width = offset_width - 2; // 8 beats per line.
   localparam int tag_width = bus_addr_width - (index_width + offset_width + 2);
   localparam int line_count = 2 ** index_width;

   // ######################################################################
   // memory bus and instruction words
   // ######################################################################
   localparam int beat_shift = 4; // 16 bytes per beat.
   localparam int bus_data_width = 8 * (2 ** beat_shift);
   localparam int words_per_beat = bus_data_width / 32;
   localparam int instr_width = 30; // bits 31 to 2 of a word.
   localparam logic [instr_width-1:0] illegal_instr = '0;

   // rv32i major opcodes, instruction bits 6 to 2.
   typedef enum logic [4:0] {
      opc_load     = 5'b00000,
      opc_misc_mem = 5'b00011,
      opc_op_imm   = 5'b00100,
      opc_auipc    = 5'b00101,
      opc_store    = 5'b01000,
      opc_op       = 5'b01100,
      opc_lui      = 5'b01101,
      opc_branch   = 5'b11000,
      opc_jalr     = 5'b11001,
      opc_jal      = 5'b11011,
      opc_system   = 5'b11100
   } opcode_e;

   typedef enum logic [2:0] {
      cls_alu     = 3'd0,
      cls_mem     = 3'd1,
      cls_ctrl    = 3'd2,
      cls_sys     = 3'd3,
      cls_illegal = 3'd4
   } instr_class_e;

   typedef enum logic [1:0] {
      st_idle,
      st_request,
      st_wait_beat
   } refill_state_e;

endpackage

/* icache/icache_line_store.sv */
module icache_line_store (
   input  logic clk_i,
   input  logic [icache_pkg::offset_width-1:0] offset_i,
   input  logic beat_we_i,
   input  logic [icache_pkg::beat_count_width-1:0] beat_i,
   input  logic [icache_pkg::words_per_beat*icache_pkg::instr_width-1:0] beat_words_i,
   output logic [icache_pkg::instr_width-1:0] instr_o
);
   import icache_pkg::*;

   localparam int word_count = 2 ** offset_width;
   localparam int word_sel_width = offset_width - beat_count_width;

   logic [instr_width-1:0] mem [word_count];

   // ######################################################################
   // beat write
   // ######################################################################
   // one beat fills four neighbouring words of the line.
   always_ff @(posedge clk_i) begin
      if (beat_we_i) begin
         for (int w = 0; w < words_per_beat; w++) begin
            mem[{beat_i, word_sel_width'(w)}] <= beat_words_i[instr_width*w +: instr_width];
         end
      end
   end

   // ######################################################################
   // word read
   // ######################################################################
   assign instr_o = mem[offset_i]; // same-cycle read.

endmodule

/* icache/instr_cache.sv */
module instr_cache (
   input  logic clk_i,
   input  logic rst_i,
   input  logic [icache_pkg::bus_addr_width-1:2] addr_i,
   input  logic [icache_pkg::bus_data_width-1:0] bus_data_i,
   input  logic bus_valid_i,
   output logic [icache_pkg::instr_width-1:0] instr_o,
   output logic hit_n_o,
   output logic [icache_pkg::bus_addr_width-1:icache_pkg::beat_shift] bus_addr_o,
   output logic bus_req_o,
   output logic flushing_n_o
);
   import icache_pkg::*;

   logic [tag_width-1:0] tag;
   logic [index_width-1:0] index;
   logic [offset_width-1:0] offset;
   logic [beat_count_width-1:0] req_beat;

   assign offset = addr_i[offset_width+1:2];
   assign index = addr_i[offset_width+index_width+1:offset_width+2];
   assign tag = addr_i[bus_addr_width-1:offset_width+index_width+2];
   assign req_beat = offset[offset_width-1:2];

   logic [tag_width-1:0] line_tag [line_count];
   logic [line_count-1:0] line_valid;
   logic access_valid;

   refill_state_e state;
   logic [index_width-1:0] refill_index;
   logic [beat_count_width-1:0] beat_cnt;
   logic last_beat;

   assign access_valid = line_valid[index] && (line_tag[index] == tag);
   assign last_beat = &beat_cnt;

   // ######################################################################
   // refill controller
   // ######################################################################
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state <= st_request; // line 0 loads right after reset.
         refill_index <= '0;
         beat_cnt <= '0;
         line_valid <= line_count'(1);
         line_tag[0] <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (!access_valid) begin
                  state <= st_request;
                  line_tag[index] <= tag;
                  line_valid[index] <= 1'b1;
                  refill_index <= index;
                  beat_cnt <= '0;
               end
            end
            st_request: begin
               if (bus_valid_i) begin
                  state <= st_wait_beat; // drop the request.
               end
            end
            st_wait_beat: begin
               beat_cnt <= beat_cnt + 1'b1;
               state <= last_beat ? st_idle : st_request;
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   assign bus_req_o = (state == st_request);
   assign flushing_n_o = (state == st_idle);
   assign bus_addr_o = {line_tag[refill_index], refill_index, beat_cnt};

   // ######################################################################
   // beat validation and line storage
   // ######################################################################
   logic [words_per_beat*instr_width-1:0] beat_words;
   logic [instr_width-1:0] line_instr [line_count];
   logic beat_wr;

   assign beat_wr = (state == st_request) && bus_valid_i;

   for (genvar l = 0; l < words_per_beat; l++) begin : g_lane
      instr_validator i_validator (
         .data_i  (bus_data_i[32*l +: 32]),
         .instr_o (beat_words[instr_width*l +: instr_width])
      );
   end

   for (genvar i = 0; i < line_count; i++) begin : g_line
      icache_line_store i_line (
         .clk_i        (clk_i),
         .offset_i     (offset),
         .beat_we_i    (beat_wr && (refill_index == i)),
         .beat_i       (beat_cnt),
         .beat_words_i (beat_words),
         .instr_o      (line_instr[i])
      );
   end

   // ######################################################################
   // hit and blocking
   // ######################################################################
   logic beat_ready;

   // a word in the refilling line counts once its beat is written.
   assign beat_ready = (state == st_idle) || (index != refill_index) ||
                       (beat_cnt > req_beat);

   assign hit_n_o = access_valid && beat_ready;
   assign instr_o = line_instr[index];

endmodule

/* icache_fetch.f */
common/icache_pkg.sv
logic/instr_validator.sv
icache/icache_line_store.sv
icache/instr_cache.sv
logic/fetch_sequencer.sv
logic/instr_decode_stage.sv
logic/icache_fetch_top.sv
verification/icache_fetch_checker.sv
verification/icache_fetch_tb.sv

/* logic/fetch_sequencer.sv */
module fetch_sequencer (
   input  logic clk_i,
   input  logic rst_i,
   input  logic redirect_i,
   input  logic [icache_pkg::bus_addr_width-1:2] redirect_pc_i,
   input  logic stall_i,
   input  logic hit_n_i,
   output logic [icache_pkg::bus_addr_width-1:2] fetch_addr_o
);
   import icache_pkg::*;

   logic [bus_addr_width-1:2] pc;

   // ######################################################################
   // program counter
   // ######################################################################
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pc <= '0;
      end else if (redirect_i) begin
         pc <= redirect_pc_i; // redirect wins over stall and hit.
      end else if (!stall_i && hit_n_i) begin
         pc <= pc + 1'b1; // next word.
      end
   end

   // holds on a miss or a stall.
   assign fetch_addr_o = pc;

endmodule

/* logic/icache_fetch_top.sv */
module icache_fetch_top (
   input  logic clk_i,
   input  logic rst_i,
   input  logic redirect_i,
   input  logic [icache_pkg::bus_addr_width-1:2] redirect_pc_i,
   input  logic stall_i,
   input  logic [icache_pkg::bus_data_width-1:0] bus_data_i,
   input  logic bus_valid_i,
   output logic [icache_pkg::bus_addr_width-1:icache_pkg::beat_shift] bus_addr_o,
   output logic bus_req_o,
   output logic flushing_n_o,
   output logic issue_valid_o,
   output logic [icache_pkg::bus_addr_width-1:2] issue_pc_o,
   output logic [icache_pkg::instr_width-1:0] issue_instr_o,
   output icache_pkg::instr_class_e issue_class_o
);
   import icache_pkg::*;

   logic [bus_addr_width-1:2] fetch_addr;
   logic [instr_width-1:0] instr;
   logic hit_n; // high when the word is ready.

   fetch_sequencer i_seq (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .redirect_i    (redirect_i),
      .redirect_pc_i (redirect_pc_i),
      .stall_i       (stall_i),
      .hit_n_i       (hit_n),
      .fetch_addr_o  (fetch_addr)
   );

   instr_cache i_cache (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .addr_i       (fetch_addr),
      .bus_data_i   (bus_data_i),
      .bus_valid_i  (bus_valid_i),
      .instr_o      (instr),
      .hit_n_o      (hit_n),
      .bus_addr_o   (bus_addr_o),
      .bus_req_o    (bus_req_o),
      .flushing_n_o (flushing_n_o)
   );

   instr_decode_stage i_decode (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .hit_n_i       (hit_n),
      .fetch_addr_i  (fetch_addr),
      .instr_i       (instr),
      .stall_i       (stall_i),
      .redirect_i    (redirect_i),
      .issue_valid_o (issue_valid_o),
      .issue_pc_o    (issue_pc_o),
      .issue_instr_o (issue_instr_o),
      .issue_class_o (issue_class_o)
   );

endmodule

/* logic/instr_decode_stage.sv */
module instr_decode_stage (
   input  logic clk_i,
   input  logic rst_i,
   input  logic hit_n_i,
   input  logic [icache_pkg::bus_addr_width-1:2] fetch_addr_i,
   input  logic [icache_pkg::instr_width-1:0] instr_i,
   input  logic stall_i,
   input  logic redirect_i,
   output logic issue_valid_o,
   output logic [icache_pkg::bus_addr_width-1:2] issue_pc_o,
   output logic [icache_pkg::instr_width-1:0] issue_instr_o,
   output icache_pkg::instr_class_e issue_class_o
);
   import icache_pkg::*;

   instr_class_e instr_class;
   logic take;

   // ######################################################################
   // opcode classification
   // ######################################################################
   always_comb begin
      if (instr_i == illegal_instr) begin
         instr_class = cls_illegal;
      end else begin
         case (instr_i[4:0]) // major opcode.
            opc_op, opc_op_imm, opc_lui, opc_auipc: instr_class = cls_alu;
            opc_load, opc_store, opc_misc_mem: instr_class = cls_mem;
            opc_branch, opc_jal, opc_jalr: instr_class = cls_ctrl;
            opc_system: instr_class = cls_sys;
            default: instr_class = cls_illegal;
         endcase
      end
   end

   assign take = hit_n_i && !stall_i && !redirect_i;

   // ######################################################################
   // issue register
   // ######################################################################
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         issue_valid_o <= 1'b0;
      end else begin
         issue_valid_o <= take;
      end
   end

   always_ff @(posedge clk_i) begin
      if (take) begin
         issue_pc_o <= fetch_addr_i;
         issue_instr_o <= instr_i;
         issue_class_o <= instr_class;
      end
   end

endmodule

/* logic/instr_validator.sv */
module instr_validator (
   input  logic [31:0] data_i,
   output logic [icache_pkg::instr_width-1:0] instr_o
);
   import icache_pkg::*;

   logic known_opcode;
   logic full_length;

   assign full_length = (data_i[1:0] == 2'b11); // not compressed.

   always_comb begin
      case (data_i[6:2])
         opc_load,
         opc_misc_mem,
         opc_op_imm,
         opc_auipc,
         opc_store,
         opc_op,
         opc_lui,
         opc_branch,
         opc_jalr,
         opc_jal,
         opc_system: begin
            known_opcode = 1'b1;
         end
         default: begin
            known_opcode = 1'b0;
         end
      endcase
   end

   assign instr_o = (full_length && known_opcode) ? data_i[31:2] : illegal_instr;

endmodule

/* verification/icache_fetch_checker.sv */
module icache_fetch_checker (
   input  logic clk_i,
   input  logic rst_i,
   input  logic issue_valid_i,
   input  logic [icache_pkg::bus_addr_width-1:2] issue_pc_i,
   input  logic [icache_pkg::instr_width-1:0] issue_instr_i,
   input  icache_pkg::instr_class_e issue_class_i,
   input  logic bus_req_i,
   input  logic [icache_pkg::bus_addr_width-1:icache_pkg::beat_shift] bus_addr_i,
   input  logic bus_valid_i,
   input  logic flushing_n_i,
   input  logic stall_i,
   input  logic quiet_i,
   input  int image_depth_i,
   input  int exp_total_i,
   input  logic [icache_pkg::bus_addr_width-1:2] exp_pc_i,
   input  logic [31:0] exp_word_i,
   output int issue_idx_o,
   output int value_errors_o,
   output int protocol_errors_o
);
   import icache_pkg::*;

   logic stalled_q;
   logic quiet_q;
   logic req_q;
   logic beat_q;
   logic flushing_q;
   int refill_beats;

   // ######################################################################
   // expected values from the raw memory word
   // ######################################################################
   function automatic logic known_major(input logic [4:0] major);
      case (major)
         5'b00000, 5'b00011, 5'b00100, 5'b00101, 5'b01000, 5'b01100,
         5'b01101, 5'b11000, 5'b11001, 5'b11011, 5'b11100: begin
            return 1'b1;
         end
         default: begin
            return 1'b0;
         end
      endcase
   endfunction

   function automatic logic [29:0] expected_instr(input logic [31:0] raw);
      if (raw[1:0] == 2'b11 && known_major(raw[6:2])) begin
         return raw[31:2];
      end
      return illegal_instr; // compressed or unknown.
   endfunction

   function automatic instr_class_e expected_class(input logic [31:0] raw);
      if (expected_instr(raw) == illegal_instr) begin
         return cls_illegal;
      end
      case (raw[6:2])
         5'b01100, 5'b00100, 5'b01101, 5'b00101: return cls_alu;
         5'b00000, 5'b01000, 5'b00011: return cls_mem;
         5'b11000, 5'b11011, 5'b11001: return cls_ctrl;
         5'b11100: return cls_sys;
         default: return cls_illegal;
      endcase
   endfunction

   // ######################################################################
   // monitor
   // ######################################################################
   always @(posedge clk_i) begin
      stalled_q <= stall_i; // level seen by the issue register.
      quiet_q <= quiet_i;
      beat_q <= bus_valid_i; // beat taken by the cache.
   end

   initial begin
      issue_idx_o = 0;
      value_errors_o = 0;
      protocol_errors_o = 0;
      req_q = 1'b0;
      beat_q = 1'b0;
      flushing_q = 1'b0;
      refill_beats = 0;
   end

   always @(negedge clk_i) begin
      if (!rst_i) begin
         if (issue_valid_i) begin
            if (stalled_q) begin
               $display("instruction issued while stall was high");
               protocol_errors_o = protocol_errors_o + 1;
            end
            if (issue_idx_o < exp_total_i) begin
               if (issue_pc_i !== exp_pc_i) begin
                  $display("[ERROR] issue_stream #%0d pc: expected %h actual %h",
                           issue_idx_o, exp_pc_i, issue_pc_i);
                  value_errors_o = value_errors_o + 1;
               end
               if (issue_instr_i !== expected_instr(exp_word_i)) begin
                  $display("[ERROR] issue_stream #%0d instr: expected %h actual %h",
                           issue_idx_o, expected_instr(exp_word_i), issue_instr_i);
                  value_errors_o = value_errors_o + 1;
               end
               if (issue_class_i !== expected_class(exp_word_i)) begin
                  $display("[ERROR] issue_stream #%0d class: expected %0d actual %0d",
                           issue_idx_o, expected_class(exp_word_i), issue_class_i);
                  value_errors_o = value_errors_o + 1;
               end
            end
            issue_idx_o <= issue_idx_o + 1;
         end
         if (bus_req_i && !req_q && (int'(bus_addr_i) >= image_depth_i)) begin
            $display("bus request at beat %h lies outside the memory image", bus_addr_i);
            protocol_errors_o = protocol_errors_o + 1;
         end
         if (quiet_q && bus_req_i) begin
            $display("bus request seen between a redirect into a cached line and its issue");
            protocol_errors_o = protocol_errors_o + 1;
         end
         if (beat_q) begin
            refill_beats = refill_beats + 1;
         end
         if (flushing_n_i && !flushing_q) begin
            if (refill_beats != 8) begin // a line is eight beats.
               $display("[ERROR] refill_length: expected 8 actual %0d", refill_beats);
               value_errors_o = value_errors_o + 1;
            end
            refill_beats = 0;
         end
         flushing_q = flushing_n_i;
      end
      req_q = bus_req_i && !rst_i;
   end

endmodule

/* verification/icache_fetch_golden.txt */
// kind(2) field(6) data(32). 01 beat: field beat address, data lanes 3..0.
// 02 redirect, 03 redirect into cached line, 04 stall cycles: field issue count. 05 issue: pc, word.
01_000000_00000073_00000463_0000a103_00100093
01_000001_123451b7_0020a223_0000007f_00004501
01_000002_0000000f_00000197_00000013_0000006f
01_000007_0020e233_00008067_00000013_00000013
01_000008_00000013_00000013_0ff0c293_30529073
01_000080_00000013_00000013_ffdff06f_00001117
// stall window, then redirects (line 0 tail, cached hit, line cross, conflict, refetch)
04_000004_00000000_00000000_00000000_00000005
02_000006_00000000_00000000_00000000_0000001e
03_000007_00000000_00000000_00000000_00000006
02_000008_00000000_00000000_00000000_0000001f
02_00000b_00000000_00000000_00000000_00000200
02_00000d_00000000_00000000_00000000_00000007
// expected issue stream
05_000000_00000000_00000000_00000000_00100093
05_000001_00000000_00000000_00000000_0000a103
05_000002_00000000_00000000_00000000_00000463
05_000003_00000000_00000000_00000000_00000073
05_000004_00000000_00000000_00000000_00004501
05_000005_00000000_00000000_00000000_0000007f
05_00001e_00000000_00000000_00000000_00008067
05_000006_00000000_00000000_00000000_0020a223
05_00001f_00000000_00000000_00000000_0020e233
05_000020_00000000_00000000_00000000_30529073
05_000021_00000000_00000000_00000000_0ff0c293
05_000200_00000000_00000000_00000000_00001117
05_000201_00000000_00000000_00000000_ffdff06f
05_000007_00000000_00000000_00000000_123451b7
05_000008_00000000_00000000_00000000_0000006f

/* verification/icache_fetch_tb.sv */
module icache_fetch_tb;
   import icache_pkg::*;

   localparam int golden_depth = 64;
   localparam int image_depth = 256;
   localparam int list_depth = 32;

   logic clk_i;
   logic rst_i;
   logic redirect_i;
   logic [bus_addr_width-1:2] redirect_pc_i;
   logic stall_i;
   logic [bus_data_width-1:0] bus_data_i;
   logic bus_valid_i;
   logic [bus_addr_width-1:beat_shift] bus_addr_o;
   logic bus_req_o;
   logic flushing_n_o;
   logic issue_valid_o;
   logic [bus_addr_width-1:2] issue_pc_o;
   logic [instr_width-1:0] issue_instr_o;
   instr_class_e issue_class_o;

   logic [159:0] golden [golden_depth];
   logic [bus_data_width-1:0] image [image_depth];
   logic [7:0] ev_kind [list_depth];
   int ev_count [list_depth];
   logic [31:0] ev_value [list_depth];
   logic [bus_addr_width-1:2] exp_addr [list_depth];
   logic [31:0] exp_word [list_depth];
   int ev_total;
   int exp_total;
   logic quiet;
   int chk_idx;
   int value_errors;
   int protocol_errors;
   logic [bus_addr_width-1:2] exp_pc;
   logic [31:0] exp_raw;

   assign exp_pc = (chk_idx < exp_total) ? exp_addr[chk_idx] : '0;
   assign exp_raw = (chk_idx < exp_total) ? exp_word[chk_idx] : '0;

   icache_fetch_top i_dut (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .redirect_i    (redirect_i),
      .redirect_pc_i (redirect_pc_i),
      .stall_i       (stall_i),
      .bus_data_i    (bus_data_i),
      .bus_valid_i   (bus_valid_i),
      .bus_addr_o    (bus_addr_o),
      .bus_req_o     (bus_req_o),
      .flushing_n_o  (flushing_n_o),
      .issue_valid_o (issue_valid_o),
      .issue_pc_o    (issue_pc_o),
      .issue_instr_o (issue_instr_o),
      .issue_class_o (issue_class_o)
   );

   icache_fetch_checker i_checker (
      .clk_i             (clk_i),
      .rst_i             (rst_i),
      .issue_valid_i     (issue_valid_o),
      .issue_pc_i        (issue_pc_o),
      .issue_instr_i     (issue_instr_o),
      .issue_class_i     (issue_class_o),
      .bus_req_i         (bus_req_o),
      .bus_addr_i        (bus_addr_o),
      .bus_valid_i       (bus_valid_i),
      .flushing_n_i      (flushing_n_o),
      .stall_i           (stall_i),
      .quiet_i           (quiet),
      .image_depth_i     (image_depth),
      .exp_total_i       (exp_total),
      .exp_pc_i          (exp_pc),
      .exp_word_i        (exp_raw),
      .issue_idx_o       (chk_idx),
      .value_errors_o    (value_errors),
      .protocol_errors_o (protocol_errors)
   );

   always #20 clk_i = ~clk_i;

   function automatic logic [bus_data_width-1:0] fetch_beat(input int beat);
      if (beat < image_depth) begin
         return image[beat];
      end
      return '0;
   endfunction

   // ######################################################################
   // memory bus model
   // ######################################################################
   initial begin
      int delay;
      int seed_val;
      seed_val = $urandom(32'hf6de);
      wait (rst_i === 1'b0);
      forever begin
         @(negedge clk_i);
         if (!rst_i && bus_req_o) begin
            delay = 1 + ($urandom % 4);
            repeat (delay) @(negedge clk_i);
            bus_data_i = fetch_beat(int'(bus_addr_o));
            bus_valid_i = 1'b1;
            @(negedge clk_i);
            bus_valid_i = 1'b0;
         end
      end
   end

   // ######################################################################
   // golden data, reset and event replay
   // ######################################################################
   initial begin
      int issued;
      int cycles;
      int limit;
      int stall_left;
      int ev_next;
      logic timed_out;
      clk_i = 1'b0;
      rst_i = 1'b1;
      redirect_i = 1'b0;
      redirect_pc_i = '0;
      stall_i = 1'b0;
      bus_data_i = '0;
      bus_valid_i = 1'b0;
      quiet = 1'b0;
      ev_total = 0;
      exp_total = 0;
      for (int g = 0; g < golden_depth; g++) begin
         golden[g] = '0;
      end
      for (int a = 0; a < image_depth; a++) begin
         for (int lane = 0; lane < 4; lane++) begin
            // addi x1 with an immediate built from beat and lane.
            image[a][32*lane +: 32] = {8'(a), 2'(lane), 2'b00, 5'd0, 3'd0, 5'd1, 7'h13};
         end
      end
      $readmemh("verification/icache_fetch_golden.txt", golden);
      for (int g = 0; g < golden_depth; g++) begin
         case (golden[g][159:152])
            8'h01: begin
               image[golden[g][151:128]] = golden[g][127:0];
            end
            8'h02, 8'h03, 8'h04: begin
               ev_kind[ev_total] = golden[g][159:152];
               ev_count[ev_total] = int'(golden[g][151:128]);
               ev_value[ev_total] = golden[g][31:0];
               ev_total++;
            end
            8'h05: begin
               exp_addr[exp_total] = golden[g][128+bus_addr_width-3:128];
               exp_word[exp_total] = golden[g][31:0];
               exp_total++;
            end
            default: begin
            end
         endcase
      end
      limit = 200 * exp_total + 2000;
      issued = 0;
      cycles = 0;
      stall_left = 0;
      ev_next = 0;
      timed_out = 1'b0;

      repeat (8) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;

      while (issued < exp_total && !timed_out) begin
         @(negedge clk_i);
         cycles++;
         redirect_i = 1'b0; // one-cycle strobe.
         if (issue_valid_o) begin
            issued++;
            quiet = 1'b0;
         end
         if (stall_left > 0) begin
            stall_left--;
            if (stall_left == 0) begin
               stall_i = 1'b0;
            end
         end else if (ev_next < ev_total && issued >= ev_count[ev_next]) begin
            if (ev_kind[ev_next] == 8'h04) begin
               stall_i = 1'b1;
               stall_left = int'(ev_value[ev_next]);
            end else begin
               redirect_i = 1'b1;
               redirect_pc_i = ev_value[ev_next][bus_addr_width-3:0];
               quiet = (ev_kind[ev_next] == 8'h03); // target line is cached.
            end
            ev_next++;
         end
         if (cycles >= limit) begin
            $display("timeout: issue stream ended early after %0d of %0d issues",
                     issued, exp_total);
            timed_out = 1'b1;
         end
      end
      repeat (2) @(negedge clk_i);

      $display("value errors: %0d, protocol errors: %0d, timeouts: %0d",
               value_errors, protocol_errors, timed_out);
      if (value_errors == 0 && protocol_errors == 0 && !timed_out) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule
